/* design/crc_bus_pkg.sv */
// AHB-Lite side definitions; register offsets are word indices taken from HADDR[4:2]
package crc_bus_pkg;

	//////////////////////////////////////////////////////////////////////
	// AHB encodings
	//////////////////////////////////////////////////////////////////////

	// HTRANS transfer types
	typedef enum logic [1:0] {
		IDLE   = 2'b00,
		BUSY   = 2'b01,
		NONSEQ = 2'b10,
		SEQ    = 2'b11
	} htrans_t;

	// Low two bits of HSIZE
	typedef enum logic [1:0] {
		BYTE = 2'b00,
		HALF = 2'b01,
		WORD = 2'b10
	} xfer_size_t;

	// Slave never signals an error
	localparam logic HRESP_OKAY = 1'b0;

	//////////////////////////////////////////////////////////////////////
	// Register map
	//////////////////////////////////////////////////////////////////////

	localparam logic [2:0] OFS_DR   = 3'd0;
	localparam logic [2:0] OFS_IDR  = 3'd1;
	localparam logic [2:0] OFS_CR   = 3'd2;
	localparam logic [2:0] OFS_INIT = 3'd4;
	localparam logic [2:0] OFS_POL  = 3'd5;

	// CR layout: bit 0 restart, bits 7:3 configuration
	localparam int CR_RESTART_BIT = 0;
	localparam int CR_CFG_LSB     = 3;
	localparam int CR_CFG_MSB     = 7;

	// Register select, same code as the offset where one exists
	typedef enum logic [2:0] {
		SEL_DR   = OFS_DR,
		SEL_IDR  = OFS_IDR,
		SEL_CR   = OFS_CR,
		SEL_INIT = OFS_INIT,
		SEL_POL  = OFS_POL,
		SEL_NONE = 3'd7
	} reg_sel_t;

	// Registered address phase
	typedef struct packed {
		logic       valid;
		logic       write;
		reg_sel_t   sel;
		xfer_size_t size;
	} addr_phase_t;

	// Engine register writes, each strobe lasts one cycle
	typedef struct packed {
		logic        init_we;
		logic        poly_we;
		logic        idr_we;
		logic        restart;
		logic [31:0] data;
	} reg_write_t;

endpackage

/* design/crc_core_pkg.sv */
// CRC core definitions; needs crc_bus_pkg compiled first for the transfer size type
package crc_core_pkg;

	// Polynomial width selected in CR
	typedef enum logic [1:0] {
		P32 = 2'b00,
		P16 = 2'b01,
		P8  = 2'b10,
		P7  = 2'b11
	} poly_size_t;

	// Input bit reversal granularity
	typedef enum logic [1:0] {
		REV_NONE = 2'b00,
		REV_BYTE = 2'b01,
		REV_HALF = 2'b10,
		REV_WORD = 2'b11
	} rev_in_t;

	// CR contents, MSB first as in CR bits 7:3
	typedef struct packed {
		logic       rev_out;
		rev_in_t    rev_in;
		poly_size_t poly_size;
	} crc_cfg_t;

	// Word handed from the buffer to the engine
	typedef struct packed {
		logic [31:0]             data;
		crc_bus_pkg::xfer_size_t size;
	} data_word_t;

	typedef enum logic {
		E_IDLE  = 1'b0,
		E_SHIFT = 1'b1
	} eng_state_t;

	//////////////////////////////////////////////////////////////////////
	// Reset values
	//////////////////////////////////////////////////////////////////////

	localparam logic [31:0] RESET_INIT = 32'hFFFF_FFFF;
	localparam logic [31:0] RESET_POLY = 32'h04C1_1DB7;
	localparam crc_cfg_t    RESET_CFG  = '0;

endpackage

/* design/crc_host_interface.sv */
// Word-aligned NONSEQ transfers only; SEQ and BUSY are ignored and HRESP is always OKAY
module crc_host_interface
(
	input  logic                       HCLK,
	input  logic                       HRESETn,
	input  logic                       HSELx,
	input  logic [31:0]                HADDR,
	input  crc_bus_pkg::htrans_t       HTRANS,
	input  logic [2:0]                 HSIZE,
	input  logic                       HWRITE,
	input  logic [31:0]                HWDATA,
	input  logic                       HREADY,
	output logic [31:0]                HRDATA,
	output logic                       HREADYOUT,
	output logic                       HRESP,
	output logic                       dr_write,
	output crc_core_pkg::data_word_t   dr_word,
	output crc_bus_pkg::reg_write_t    reg_wr,
	output crc_core_pkg::crc_cfg_t     cfg,
	input  logic                       buffer_full,
	input  logic                       busy,
	input  logic                       restart_pending,
	input  logic [31:0]                crc_result,
	input  logic [31:0]                init_value,
	input  logic [31:0]                poly_value,
	input  logic [7:0]                 idr_value
);

	crc_bus_pkg::addr_phase_t ap_q;
	crc_bus_pkg::reg_sel_t    addr_sel;
	crc_core_pkg::crc_cfg_t   cfg_q;
	logic                     sample_bus;
	logic                     wr_access;
	logic                     rd_access;
	logic                     dr_wr;
	logic                     dr_rd;
	logic                     init_wr;
	logic                     cr_wr;
	logic                     stall;
	logic [31:0]              cr_read;

	//////////////////////////////////////////////////////////////////////
	// Address phase
	//////////////////////////////////////////////////////////////////////

	// Offsets 3, 6 and 7 are unmapped
	always_comb
	begin
		case (HADDR[4:2])
			crc_bus_pkg::OFS_DR:   addr_sel = crc_bus_pkg::SEL_DR;
			crc_bus_pkg::OFS_IDR:  addr_sel = crc_bus_pkg::SEL_IDR;
			crc_bus_pkg::OFS_CR:   addr_sel = crc_bus_pkg::SEL_CR;
			crc_bus_pkg::OFS_INIT: addr_sel = crc_bus_pkg::SEL_INIT;
			crc_bus_pkg::OFS_POL:  addr_sel = crc_bus_pkg::SEL_POL;
			default:               addr_sel = crc_bus_pkg::SEL_NONE;
		endcase
	end

	// Bus is only sampled when no wait state is pending
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			ap_q <= '{valid: 1'b0, write: 1'b0, sel: crc_bus_pkg::SEL_NONE,
				size: crc_bus_pkg::BYTE};
		end
		else if (sample_bus)
		begin
			// Only NONSEQ to this slave starts a transfer
			ap_q.valid <= HSELx && (HTRANS == crc_bus_pkg::NONSEQ);
			ap_q.write <= HWRITE;
			ap_q.sel   <= addr_sel;
			ap_q.size  <= crc_bus_pkg::xfer_size_t'(HSIZE[1:0]);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Data phase decode and wait states
	//////////////////////////////////////////////////////////////////////

	assign wr_access = ap_q.valid && ap_q.write;
	assign rd_access = ap_q.valid && !ap_q.write;
	assign dr_wr     = wr_access && (ap_q.sel == crc_bus_pkg::SEL_DR);
	assign dr_rd     = rd_access && (ap_q.sel == crc_bus_pkg::SEL_DR);
	assign init_wr   = wr_access && (ap_q.sel == crc_bus_pkg::SEL_INIT);
	assign cr_wr     = wr_access && (ap_q.sel == crc_bus_pkg::SEL_CR);

	// DR read also waits out a queued restart so it sees the reloaded CRC
	assign stall = (dr_wr && buffer_full) ||
		(dr_rd && (buffer_full || busy || restart_pending)) ||
		(init_wr && restart_pending);

	assign HREADYOUT = !stall;
	assign HRESP     = crc_bus_pkg::HRESP_OKAY;

	// DR write goes straight into the buffer
	assign dr_write = dr_wr && !buffer_full;
	assign dr_word  = '{data: HWDATA, size: ap_q.size};

	always_comb
	begin
		reg_wr.init_we = init_wr && !restart_pending;
		reg_wr.poly_we = wr_access && (ap_q.sel == crc_bus_pkg::SEL_POL);
		reg_wr.idr_we  = wr_access && (ap_q.sel == crc_bus_pkg::SEL_IDR);
		// Restart bit self clears, only the strobe exists
		reg_wr.restart = cr_wr && HWDATA[crc_bus_pkg::CR_RESTART_BIT];
		reg_wr.data    = HWDATA;
	end

	//////////////////////////////////////////////////////////////////////
	// Control register and read mux
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			cfg_q <= crc_core_pkg::RESET_CFG;
		else if (cr_wr)
			cfg_q <= crc_core_pkg::crc_cfg_t'(
				HWDATA[crc_bus_pkg::CR_CFG_MSB:crc_bus_pkg::CR_CFG_LSB]);
	end

	assign cfg = cfg_q;

	// Config fields back in their CR bit positions
	assign cr_read = 32'(cfg_q) << crc_bus_pkg::CR_CFG_LSB;

	always_comb
	begin
		case (ap_q.sel)
			crc_bus_pkg::SEL_DR:   HRDATA = crc_result;
			crc_bus_pkg::SEL_IDR:  HRDATA = {24'h0, idr_value};
			crc_bus_pkg::SEL_CR:   HRDATA = cr_read;
			crc_bus_pkg::SEL_INIT: HRDATA = init_value;
			crc_bus_pkg::SEL_POL:  HRDATA = poly_value;
			default:               HRDATA = '0;
		endcase
	end

endmodule

/* design/crc_input_buffer.sv */
// One word deep; a new write is only taken while empty, reversal fixed at capture time
module crc_input_buffer
(
	input  logic                     HCLK,
	input  logic                     HRESETn,
	input  logic                     dr_write,
	input  crc_core_pkg::data_word_t dr_word,
	input  crc_core_pkg::rev_in_t    rev_in,
	input  logic                     word_take,
	output logic                     word_valid,
	output logic                     buffer_full,
	output crc_core_pkg::data_word_t word_out
);

	logic [31:0] rev8;
	logic [31:0] rev16;
	logic [31:0] rev32;
	logic [31:0] rev_data;

	// Mirror bits at each granularity
	always_comb
	begin
		for (int i = 0; i < 32; i++)
		begin
			rev8[i]  = dr_word.data[(i & ~7) + (7 - (i & 7))];
			rev16[i] = dr_word.data[(i & ~15) + (15 - (i & 15))];
			rev32[i] = dr_word.data[31 - i];
		end
	end

	// Reversal never spans beyond the transfer size
	always_comb
	begin
		case (rev_in)
			crc_core_pkg::REV_BYTE: rev_data = rev8;
			crc_core_pkg::REV_HALF:
				rev_data = (dr_word.size == crc_bus_pkg::BYTE) ? rev8 : rev16;
			crc_core_pkg::REV_WORD:
				case (dr_word.size)
					crc_bus_pkg::BYTE: rev_data = rev8;
					crc_bus_pkg::HALF: rev_data = rev16;
					default:           rev_data = rev32;
				endcase
			default: rev_data = dr_word.data;
		endcase
	end

	// Occupancy flag
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			word_valid <= 1'b0;
		else if (dr_write)
			word_valid <= 1'b1;
		else if (word_take)
			word_valid <= 1'b0;
	end

	// Payload
	always_ff @(posedge HCLK)
	begin
		if (dr_write)
			word_out <= '{data: rev_data, size: dr_word.size};
	end

	assign buffer_full = word_valid;

endmodule

/* design/crc_engine.sv */
// MSB-first non-reflected CRC, one byte per clock; restart waits for idle engine and empty buffer
module crc_engine
(
	input  logic                     HCLK,
	input  logic                     HRESETn,
	input  crc_core_pkg::crc_cfg_t   cfg,
	input  crc_bus_pkg::reg_write_t  reg_wr,
	input  logic                     word_valid,
	input  crc_core_pkg::data_word_t word_in,
	output logic                     word_take,
	output logic                     busy,
	output logic                     restart_pending,
	output logic [31:0]              crc_result,
	output logic [31:0]              init_value,
	output logic [31:0]              poly_value,
	output logic [7:0]               idr_value
);

	crc_core_pkg::eng_state_t state_q;
	logic [31:0]              crc_q;
	logic [31:0]              init_q;
	logic [31:0]              poly_q;
	logic [7:0]               idr_q;
	logic [31:0]              shift_q;
	logic [1:0]               count_q;
	logic [31:0]              aligned;
	logic [1:0]               bytes_m1;
	logic [31:0]              width_mask;
	logic [31:0]              masked_crc;
	logic [31:0]              mirrored;
	logic                     restart_now;

	// One byte of polynomial division, MSB first
	function automatic logic [31:0] crc_byte(input logic [31:0] crc, input logic [7:0] din,
		input logic [31:0] poly, input logic [31:0] mask);
		logic [31:0] c;
		logic [31:0] top;
		logic        fb;
		c   = crc & mask;
		top = mask & ~(mask >> 1);
		for (int i = 7; i >= 0; i--)
		begin
			fb = (|(c & top)) ^ din[i];
			c  = (c << 1) & mask;
			if (fb)
				c = c ^ (poly & mask);
		end
		return c;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Programmable registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			init_q <= crc_core_pkg::RESET_INIT;
			poly_q <= crc_core_pkg::RESET_POLY;
			idr_q  <= 8'h00;
		end
		else
		begin
			if (reg_wr.init_we)
				init_q <= reg_wr.data;
			if (reg_wr.poly_we)
				poly_q <= reg_wr.data;
			if (reg_wr.idr_we)
				idr_q <= reg_wr.data[7:0];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Byte-serial state machine
	//////////////////////////////////////////////////////////////////////

	// Move the first byte of the transfer to the top
	always_comb
	begin
		case (word_in.size)
			crc_bus_pkg::BYTE:
			begin
				aligned  = {word_in.data[7:0], 24'h0};
				bytes_m1 = 2'd0;
			end
			crc_bus_pkg::HALF:
			begin
				aligned  = {word_in.data[15:0], 16'h0};
				bytes_m1 = 2'd1;
			end
			default:
			begin
				aligned  = word_in.data;
				bytes_m1 = 2'd3;
			end
		endcase
	end

	assign word_take   = (state_q == crc_core_pkg::E_IDLE) && word_valid;
	assign busy        = (state_q == crc_core_pkg::E_SHIFT);
	// Pending words are folded in before a restart
	assign restart_now = (reg_wr.restart || restart_pending) &&
		(state_q == crc_core_pkg::E_IDLE) && !word_valid;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			state_q <= crc_core_pkg::E_IDLE;
			count_q <= 2'd0;
		end
		else
			case (state_q)
				crc_core_pkg::E_IDLE:
					if (word_valid)
					begin
						state_q <= crc_core_pkg::E_SHIFT;
						count_q <= bytes_m1;
					end
				default:
					if (count_q == 2'd0)
						state_q <= crc_core_pkg::E_IDLE;
					else
						count_q <= count_q - 2'd1;
			endcase
	end

	// Shift register payload
	always_ff @(posedge HCLK)
	begin
		if (word_take)
			shift_q <= aligned;
		else if (busy)
			shift_q <= shift_q << 8;
	end

	// CRC register and restart
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_q           <= crc_core_pkg::RESET_INIT;
			restart_pending <= 1'b0;
		end
		else
		begin
			if (restart_now)
				crc_q <= init_q;
			else if (busy)
				crc_q <= crc_byte(crc_q, shift_q[31:24], poly_q, width_mask);
			if (restart_now)
				restart_pending <= 1'b0;
			else if (reg_wr.restart)
				restart_pending <= 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Result formatting
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (cfg.poly_size)
			crc_core_pkg::P16: width_mask = 32'h0000_FFFF;
			crc_core_pkg::P8:  width_mask = 32'h0000_00FF;
			crc_core_pkg::P7:  width_mask = 32'h0000_007F;
			default:           width_mask = 32'hFFFF_FFFF;
		endcase
	end

	assign masked_crc = crc_q & width_mask;

	// Mirror within the polynomial width
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			mirrored[i] = masked_crc[31 - i];
		case (cfg.poly_size)
			crc_core_pkg::P16: mirrored = {16'h0, mirrored[31:16]};
			crc_core_pkg::P8:  mirrored = {24'h0, mirrored[31:24]};
			crc_core_pkg::P7:  mirrored = {25'h0, mirrored[31:25]};
			default:           mirrored = mirrored;
		endcase
	end

	assign crc_result = cfg.rev_out ? mirrored : masked_crc;
	assign init_value = init_q;
	assign poly_value = poly_q;
	assign idr_value  = idr_q;

endmodule

/* design/crc_ahb_top.sv */
// AHB-Lite CRC slave; HREADY must be the system ready, HSIZE above word is not supported
module crc_ahb_top
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        HSELx,
	input  logic [31:0] HADDR,
	input  logic [1:0]  HTRANS,
	input  logic [2:0]  HSIZE,
	input  logic        HWRITE,
	input  logic [31:0] HWDATA,
	input  logic        HREADY,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	// Host interface to buffer
	logic                     dr_write;
	crc_core_pkg::data_word_t dr_word;
	logic                     buffer_full;

	// Buffer to engine
	logic                     word_valid;
	logic                     word_take;
	crc_core_pkg::data_word_t word_out;

	// Host interface to engine
	crc_bus_pkg::reg_write_t  reg_wr;
	crc_core_pkg::crc_cfg_t   cfg;
	logic                     busy;
	logic                     restart_pending;
	logic [31:0]              crc_result;
	logic [31:0]              init_value;
	logic [31:0]              poly_value;
	logic [7:0]               idr_value;

	crc_host_interface crc_host_interface_inst
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.HSELx           (HSELx),
		.HADDR           (HADDR),
		.HTRANS          (crc_bus_pkg::htrans_t'(HTRANS)),
		.HSIZE           (HSIZE),
		.HWRITE          (HWRITE),
		.HWDATA          (HWDATA),
		.HREADY          (HREADY),
		.HRDATA          (HRDATA),
		.HREADYOUT       (HREADYOUT),
		.HRESP           (HRESP),
		.dr_write        (dr_write),
		.dr_word         (dr_word),
		.reg_wr          (reg_wr),
		.cfg             (cfg),
		.buffer_full     (buffer_full),
		.busy            (busy),
		.restart_pending (restart_pending),
		.crc_result      (crc_result),
		.init_value      (init_value),
		.poly_value      (poly_value),
		.idr_value       (idr_value)
	);

	crc_input_buffer crc_input_buffer_inst
	(
		.HCLK        (HCLK),
		.HRESETn     (HRESETn),
		.dr_write    (dr_write),
		.dr_word     (dr_word),
		.rev_in      (cfg.rev_in),
		.word_take   (word_take),
		.word_valid  (word_valid),
		.buffer_full (buffer_full),
		.word_out    (word_out)
	);

	crc_engine crc_engine_inst
	(
		.HCLK            (HCLK),
		.HRESETn         (HRESETn),
		.cfg             (cfg),
		.reg_wr          (reg_wr),
		.word_valid      (word_valid),
		.word_in         (word_out),
		.word_take       (word_take),
		.busy            (busy),
		.restart_pending (restart_pending),
		.crc_result      (crc_result),
		.init_value      (init_value),
		.poly_value      (poly_value),
		.idr_value       (idr_value)
	);

endmodule

/* tb/crc_ahb_tb.sv */
// Single AHB master on a single slave (HREADY tied to HREADYOUT); run from the project root
module crc_ahb_tb;

	timeunit 1ns;
	timeprecision 100ps;

	// DUT ports
	logic        HCLK;
	logic        HRESETn;
	logic        HSELx;
	logic [31:0] HADDR;
	logic [1:0]  HTRANS;
	logic [2:0]  HSIZE;
	logic        HWRITE;
	logic [31:0] HWDATA;
	logic        HREADY;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Case table with one entry per file line
	int          case_test[$];
	string       case_op[$];
	string       case_reg[$];
	int          case_size[$];
	logic [31:0] case_data[$];
	logic [31:0] case_expect[$];
	int          case_gap[$];

	// Bookkeeping
	int          seed = 25924;
	int          timeout_limit = 1000;
	int          cycle_count = 0;
	int          check_count = 0;
	int          error_count = 0;
	int          test_checks = 0;
	int          test_errors = 0;
	int          tests_done = 0;
	int          tests_failed = 0;
	int          wait_cycles = 0;
	int          current_test = -1;

	// Only one slave so the system ready is the slave's own
	assign HREADY = HREADYOUT;

	crc_ahb_top crc_ahb_top_inst
	(
		.HCLK      (HCLK),
		.HRESETn   (HRESETn),
		.HSELx     (HSELx),
		.HADDR     (HADDR),
		.HTRANS    (HTRANS),
		.HSIZE     (HSIZE),
		.HWRITE    (HWRITE),
		.HWDATA    (HWDATA),
		.HREADY    (HREADY),
		.HRDATA    (HRDATA),
		.HREADYOUT (HREADYOUT),
		.HRESP     (HRESP)
	);

	//////////////////////////////////////////////////////////////////////
	// Clock and timeout
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		HCLK = 1'b0;
		forever
			#2 HCLK = ~HCLK;
	end

	always @(posedge HCLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_limit)
		begin
			$display("Timeout: the run stopped waiting for HREADYOUT after %0d cycles",
				cycle_count);
			$display("Test failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////////////////////////

	// Byte address of a register name from its word offset in the map
	function automatic logic [31:0] reg_address(input string name);
		case (name)
			"DR":    return 32'h00;
			"IDR":   return 32'h04;
			"CR":    return 32'h08;
			"U3":    return 32'h0C;
			"INIT":  return 32'h10;
			"POL":   return 32'h14;
			"U6":    return 32'h18;
			default: return 32'h1C;
		endcase
	endfunction

	// One NONSEQ transfer entered and left just after a rising edge
	task automatic bus_transfer(input logic write, input logic [31:0] addr,
		input int size, input logic [31:0] data, output logic [31:0] rdata,
		output logic resp);
		// Address phase
		HSELx  <= 1'b1;
		HTRANS <= 2'b10;
		HADDR  <= addr;
		HWRITE <= write;
		HSIZE  <= 3'(size);
		@(posedge HCLK);
		// Data phase with the bus idle behind it
		HSELx  <= 1'b0;
		HTRANS <= 2'b00;
		HWDATA <= data;
		forever
		begin
			@(negedge HCLK);
			if (HREADYOUT)
				break;
			wait_cycles++;
		end
		rdata = HRDATA;
		resp  = HRESP;
		@(posedge HCLK);
	endtask

	// Summary line for the test that just ended
	task automatic close_test();
		if (current_test < 0)
			return;
		tests_done++;
		if (test_errors != 0)
			tests_failed++;
		$display("test %0d: %s, %0d checks, %0d wrong", current_test,
			(test_errors == 0) ? "ok" : "FAILED", test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	// Read cases and skip comment lines
	task automatic load_cases(output int ok);
		int          fd;
		int          n;
		int          t;
		int          sz;
		int          g;
		string       line;
		string       op;
		string       rg;
		logic [31:0] d;
		logic [31:0] e;
		ok = 0;
		fd = $fopen("tb/crc_cases.txt", "r");
		if (fd == 0)
			return;
		while ($fgets(line, fd))
		begin
			if (line.len() < 2 || line[0] == "#")
				continue;
			n = $sscanf(line, "%d %s %s %d %h %h %d", t, op, rg, sz, d, e, g);
			if (n != 7)
				continue;
			case_test.push_back(t);
			case_op.push_back(op);
			case_reg.push_back(rg);
			case_size.push_back(sz);
			case_data.push_back(d);
			case_expect.push_back(e);
			case_gap.push_back(g);
		end
		$fclose(fd);
		ok = 1;
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		int          ok;
		int          gap;
		logic [31:0] rdata;
		logic        resp;
		HRESETn = 1'b0;
		HSELx   = 1'b0;
		HADDR   = '0;
		HTRANS  = 2'b00;
		HSIZE   = 3'd0;
		HWRITE  = 1'b0;
		HWDATA  = '0;
		load_cases(ok);
		if (ok == 0 || case_test.size() == 0)
		begin
			$display("Could not read any case from tb/crc_cases.txt");
			$display("Test failed");
			$finish;
		end
		else
		begin
			// Each line gets a generous budget of cycles
			timeout_limit = case_test.size() * 40;
			repeat (2) @(posedge HCLK);
			HRESETn <= 1'b1;
			@(posedge HCLK);
			// Slave comes out of reset ready
			@(negedge HCLK);
			check_count++;
			if (HREADYOUT !== 1'b1)
			begin
				$display("[FAIL] %0d ns: HREADYOUT low after reset", $time);
				error_count++;
			end
			@(posedge HCLK);
			foreach (case_test[i])
			begin
				if (case_test[i] != current_test)
				begin
					close_test();
					current_test = case_test[i];
				end
				// File gap plus 0 to 3 random idle cycles
				gap = case_gap[i] + ($unsigned($random(seed)) % 4);
				repeat (gap) @(posedge HCLK);
				bus_transfer(case_op[i] == "W", reg_address(case_reg[i]), case_size[i],
					case_data[i], rdata, resp);
				if (resp !== 1'b0)
				begin
					$display("[FAIL] %0d ns: %s transfer returned an error response",
						$time, case_reg[i]);
					error_count++;
					test_errors++;
				end
				if (case_op[i] == "R")
				begin
					check_count++;
					test_checks++;
					if (rdata !== case_expect[i])
					begin
						$display("[FAIL] %0d ns: %s read 0x%08h, expected 0x%08h",
							$time, case_reg[i], rdata, case_expect[i]);
						error_count++;
						test_errors++;
					end
				end
			end
			close_test();
			$display("tests %0d, failed tests %0d, checks %0d, wrong values %0d, waits %0d",
				tests_done, tests_failed, check_count, error_count, wait_cycles);
			if (error_count == 0)
				$display("Test completed successfully");
			else
				$display("Test failed");
			$finish;
		end
	end

endmodule

/* tb/crc_cases.txt */
# test op reg size(0 byte,1 half,2 word) data(hex) expect(hex) gap
# CR: bit0 restart, bits4:3 size (0=32,1=16,2=8), bits6:5 input reversal, bit7 output reversal
1 R CR   2 00000000 00000000 0
1 R INIT 2 00000000 FFFFFFFF 0
1 R POL  2 00000000 04C11DB7 1
1 R IDR  2 00000000 00000000 0
1 R DR   2 00000000 FFFFFFFF 0
2 W CR   2 00000001 00000000 0
2 W DR   2 31323334 00000000 0
2 W DR   2 35363738 00000000 0
2 W DR   0 00000039 00000000 0
2 R DR   2 00000000 0376E6E7 0
3 W POL  2 00001021 00000000 1
3 W INIT 2 0000FFFF 00000000 0
3 W CR   2 00000009 00000000 0
3 W DR   1 00003132 00000000 0
3 W DR   1 00003334 00000000 0
3 W DR   1 00003536 00000000 0
3 W DR   1 00003738 00000000 0
3 W DR   0 00000039 00000000 0
3 R DR   2 00000000 000029B1 0
3 W POL  2 00000007 00000000 2
3 W INIT 2 00000000 00000000 0
3 W CR   2 00000011 00000000 0
3 W DR   0 00000031 00000000 0
3 R DR   2 00000000 00000097 0
4 W POL  2 04C11DB7 00000000 0
4 W INIT 2 FFFFFFFF 00000000 0
4 W CR   2 00000041 00000000 0
4 W DR   1 00004C8C 00000000 0
4 W DR   1 00002CCC 00000000 0
4 W CR   2 00000060 00000000 0
4 W DR   2 1CEC6CAC 00000000 0
4 W CR   2 000000A0 00000000 0
4 W DR   0 0000009C 00000000 0
4 R DR   2 00000000 E7676EC0 0
5 W IDR  2 000000A5 00000000 1
5 R IDR  2 00000000 000000A5 0
5 R U3   2 00000000 00000000 0
5 R U6   2 00000000 00000000 0
5 W DR   2 31323334 00000000 0
5 W CR   2 00000001 00000000 0
5 W INIT 2 12345678 00000000 0
5 R DR   2 00000000 FFFFFFFF 0
5 W CR   2 00000001 00000000 0
5 R DR   2 00000000 12345678 0

/* filelist.f */
design/crc_bus_pkg.sv
design/crc_core_pkg.sv
design/crc_host_interface.sv
design/crc_input_buffer.sv
design/crc_engine.sv
design/crc_ahb_top.sv
tb/crc_ahb_tb.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := crc_ahb_tb
RTL_TOP    := crc_ahb_top
FILELIST   := filelist.f
FLAGS      := --timing --timescale 1ns/100ps
SIM_FLAGS  := --binary -j 0
PASS_TEXT  := Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf obj_dir
